/* common/fifo_cfg_pkg.sv */
// Depth, address width, pointer width and pointer types for the dual-clock FIFO
package fifo_cfg_pkg;

    //////////////////////////////
    // Storage geometry
    //////////////////////////////

    // Words held by the FIFO in total
    // One 36Kb block RAM at 72 bits wide
    localparam int fifo_depth = 512;

    // Memory address width
    localparam int fifo_addr_w = $clog2(fifo_depth);   // 9 bits for 512 words

    //////////////////////////////
    // Pointers
    //////////////////////////////

    // Pointers carry one extra wrap bit above the address
    // Equal pointers mean empty
    // Wrap bit differs with the rest equal means full
    localparam int fifo_ptr_w = fifo_addr_w + 1;       // 10 bits

    // Shared by binary and Gray pointers on both sides
    typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;

    // Memory address seen by the RAM ports
    typedef logic [fifo_addr_w-1:0] fifo_addr_t;

endpackage : fifo_cfg_pkg

/* common/fifo_data_pkg.sv */
// Payload width and FIFO word type
package fifo_data_pkg;

    //////////////////////////////
    // Payload
    //////////////////////////////

    // Full width of one FIFO entry
    // Matches the 37 to 72 bit range of a 512 deep block-RAM FIFO
    localparam int fifo_data_w = 72;

    // One stored word
    // Same type on din, in the RAM and on dout
    typedef logic [fifo_data_w-1:0] fifo_word_t;

endpackage : fifo_data_pkg

/* dv/tb_async_fifo_72.sv */
// Testbench for the dual-clock FWFT FIFO with phase table, scoreboard and compare tasks
`timescale 1ns/1ps

module tb_async_fifo_72;

    import fifo_cfg_pkg::*;
    import fifo_data_pkg::*;

    localparam int n_phases    = 7;
    localparam int stall_limit = 200;   // Idle cycles before a wait gives up

    typedef struct packed {
        int         n_wr;       // Accepted writes
        int         n_rd;       // Accepted reads
        int         over_wr;    // Writes tried while full
        int         over_rd;    // Reads tried while empty
        bit         conc;       // Writer and reader in parallel
        bit         rnd;        // Random enables
        bit         rst;        // Reset before the phase
        logic [7:0] tag;        // Data seed, top byte of every word
        logic       exp_full;   // Flags after the phase
        logic       exp_empty;
    } phase_t;

    logic       wr_clk;
    logic       rd_clk;
    logic       rst_n;
    fifo_word_t din;
    logic       wr_en;
    logic       rd_en;
    fifo_word_t dout;
    logic       full;
    logic       empty;

    phase_t     phases [n_phases];
    fifo_word_t q [$];          // Scoreboard in write order
    int         seed;
    int         check_errs;
    int         other_errs;

    tb_clk_gen #(.period_ns(40.0)) i_wr_clk_gen (.clk(wr_clk));
    tb_clk_gen #(.period_ns(56.0)) i_rd_clk_gen (.clk(rd_clk));    // Unrelated to wr_clk

    async_fifo_72 i_dut (
        .wr_clk (wr_clk),
        .rd_clk (rd_clk),
        .rst_n  (rst_n),
        .din    (din),
        .wr_en  (wr_en),
        .rd_en  (rd_en),
        .dout   (dout),
        .full   (full),
        .empty  (empty)
    );

    //////////////////////////////
    // Checks and run control
    //////////////////////////////

    task automatic check_word(input string name, input fifo_word_t got, input fifo_word_t exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", check_errs, other_errs);
        if (check_errs + other_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        other_errs++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    task automatic set_phase(input int idx, input int n_wr, input int n_rd, input int over_wr,
                             input int over_rd, input bit conc, input bit rnd, input bit rst,
                             input logic [7:0] tag, input logic exp_full, input logic exp_empty);
        phases[idx] = {n_wr, n_rd, over_wr, over_rd, conc, rnd, rst, tag, exp_full, exp_empty};
    endtask

    //////////////////////////////
    // Reset and traffic
    //////////////////////////////

    // Scoreboard cleared with the DUT and flags checked right at release
    task automatic apply_reset();
        @(negedge wr_clk);
        rst_n = 1'b0;
        wr_en = 1'b0;
        q.delete();
        repeat (16) @(negedge wr_clk);
        rst_n = 1'b1;
        check_flag(empty, 1'b1, "empty");
        check_flag(full, 1'b0, "full");
        repeat (6) @(negedge wr_clk);   // Both reset synchronizers released
    endtask

    task automatic drive_writes(input int n, input bit rnd, input logic [7:0] tag);
        int         done_cnt;
        int         stall;
        logic       en;
        fifo_word_t word;
        done_cnt = 0;
        stall    = 0;
        while (done_cnt < n) begin
            @(negedge wr_clk);
            en    = rnd ? (($random(seed) & 1) == 1) : 1'b1;
            word  = {tag, $random(seed), $random(seed)};
            wr_en = en;
            din   = word;
            if (en && !full) begin
                q.push_back(word);      // Taken on the next wr_clk edge
                done_cnt++;
                stall = 0;
            end else begin
                stall++;
                if (stall > stall_limit) abort_on_timeout("writer found no free slot");
            end
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
        if (q.size() == fifo_depth) check_flag(full, 1'b1, "full");  // Edge after last write
    endtask

    task automatic push_while_full(input int n, input logic [7:0] tag);
        fifo_word_t word;
        repeat (n) begin
            @(negedge wr_clk);
            check_flag(full, 1'b1, "full");
            word  = {tag, $random(seed), $random(seed)};
            wr_en = 1'b1;
            din   = word;
            if (!full) q.push_back(word);   // Would show up as an extra word later
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    task automatic take_word();
        if (q.size() == 0) begin
            other_errs++;
            $display("A read was accepted while no word was expected in the FIFO");
        end else begin
            check_word("dout", dout, q.pop_front());
        end
    endtask

    // FWFT data must already be on dout with rd_en low
    task automatic wait_not_empty();
        int stall;
        stall = 0;
        @(negedge rd_clk);
        while (empty) begin
            @(negedge rd_clk);
            stall++;
            if (stall > stall_limit) abort_on_timeout("empty never fell after writes");
        end
        if (q.size() > 0) check_word("dout", dout, q[0]);
    endtask

    task automatic drive_reads(input int n, input bit rnd);
        int   done_cnt;
        int   stall;
        logic en;
        done_cnt = 0;
        stall    = 0;
        if (!rnd && n > 0) wait_not_empty();
        while (done_cnt < n) begin
            @(negedge rd_clk);
            en    = rnd ? (($random(seed) & 1) == 1) : 1'b1;
            rd_en = en;
            if (en && !empty) begin
                take_word();            // dout is the word this read takes
                done_cnt++;
                stall = 0;
            end else begin
                stall++;
                if (stall > stall_limit) abort_on_timeout("reader saw no data arrive");
            end
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
    endtask

    task automatic pop_while_empty(input int n);
        repeat (n) begin
            @(negedge rd_clk);
            check_flag(empty, 1'b1, "empty");
            rd_en = 1'b1;
            if (!empty) take_word();
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
    endtask

    task automatic execute_phase(input phase_t ph);
        if (ph.rst) apply_reset();
        if (ph.conc) begin
            fork
                drive_writes(ph.n_wr, ph.rnd, ph.tag);
                drive_reads(ph.n_rd, ph.rnd);
            join
        end else begin
            drive_writes(ph.n_wr, ph.rnd, ph.tag);
            push_while_full(ph.over_wr, ph.tag);
            if (ph.over_wr > 0 && q.size() != fifo_depth) begin
                other_errs++;
                $display("Scoreboard holds %0d words after filling, not %0d",
                         q.size(), fifo_depth);
            end
            drive_reads(ph.n_rd, ph.rnd);
            pop_while_empty(ph.over_rd);
        end
        @(negedge wr_clk);
        check_flag(full, ph.exp_full, "full");
        @(negedge rd_clk);
        check_flag(empty, ph.exp_empty, "empty");
    endtask

    //////////////////////////////
    // Phase table and main flow
    //////////////////////////////

    initial begin
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        din        = '0;
        seed       = 82;
        check_errs = 0;
        other_errs = 0;
        //         idx n_wr n_rd ovw ovr conc rnd rst tag    full  empty
        set_phase(0,  8,   8,   0,  0,  0,   0,  0,  8'h11, 1'b0, 1'b1);   // Short burst
        set_phase(1,  512, 0,   6,  0,  0,   0,  0,  8'h22, 1'b1, 1'b0);   // Fill, drops
        set_phase(2,  0,   512, 0,  5,  0,   0,  0,  8'h33, 1'b0, 1'b1);   // Drain
        set_phase(3,  4,   4,   0,  0,  0,   0,  0,  8'h44, 1'b0, 1'b1);   // After idle reads
        set_phase(4,  300, 300, 0,  0,  1,   1,  0,  8'h55, 1'b0, 1'b1);   // Random traffic
        set_phase(5,  20,  5,   0,  0,  0,   0,  0,  8'h66, 1'b0, 1'b0);   // Left partly full
        set_phase(6,  8,   8,   0,  0,  0,   0,  1,  8'h77, 1'b0, 1'b1);   // Reset, then burst
        apply_reset();
        for (int i = 0; i < n_phases; i++) begin
            execute_phase(phases[i]);
        end
        finish_run();
    end

endmodule : tb_async_fifo_72

/* dv/tb_clk_gen.sv */
// Free-running testbench clock source with a period parameter
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns = 40.0     // Full clock period
) (
    output logic clk
);

    //////////////////////////////
    // Clock toggle
    //////////////////////////////

    // Starts low so the first rising edge lands half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;  // Half period per phase
        end
    end

endmodule : tb_clk_gen

/* flist.f */
common/fifo_cfg_pkg.sv
common/fifo_data_pkg.sv
rtl/async_fifo_72/fifo_dp_ram.sv
rtl/async_fifo_72/gray_ptr_sync.sv
rtl/async_fifo_72/fifo_wr_ctrl.sv
rtl/async_fifo_72/fifo_rd_ctrl.sv
rtl/async_fifo_72/async_fifo_72.sv
dv/tb_clk_gen.sv
dv/tb_async_fifo_72.sv

/* rtl/async_fifo_72/async_fifo_72.sv */
// Top level of the 72-bit dual-clock FWFT FIFO with RAM, controllers and pointer synchronizers
`timescale 1ns/1ps

module async_fifo_72 (
    input  logic                      wr_clk,
    input  logic                      rd_clk,
    input  logic                      rst_n,    // One reset for both domains
    input  fifo_data_pkg::fifo_word_t din,
    input  logic                      wr_en,
    input  logic                      rd_en,
    output fifo_data_pkg::fifo_word_t dout,
    output logic                      full,
    output logic                      empty
);

    import fifo_cfg_pkg::*;
    import fifo_data_pkg::*;

    logic       mem_we;         // Accepted write
    fifo_addr_t wr_addr;
    fifo_addr_t rd_addr;
    fifo_word_t mem_rdata;      // RAM to output register
    fifo_ptr_t  wr_gray;        // Write domain
    fifo_ptr_t  wr_gray_sync;   // Read domain copy
    fifo_ptr_t  rd_gray;        // Read domain
    fifo_ptr_t  rd_gray_sync;   // Write domain copy

    fifo_dp_ram i_ram (
        .wr_clk  (wr_clk),
        .wr_en   (mem_we),
        .wr_addr (wr_addr),
        .wr_data (din),         // Straight from the input
        .rd_addr (rd_addr),
        .rd_data (mem_rdata)
    );

    fifo_wr_ctrl i_wr_ctrl (
        .wr_clk       (wr_clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .rd_gray_sync (rd_gray_sync),
        .mem_we       (mem_we),
        .wr_addr      (wr_addr),
        .wr_gray      (wr_gray),
        .full         (full)
    );

    gray_ptr_sync i_wr2rd_sync (
        .clk     (rd_clk),
        .rst_n   (rst_n),
        .ptr_in  (wr_gray),
        .ptr_out (wr_gray_sync)
    );

    gray_ptr_sync i_rd2wr_sync (
        .clk     (wr_clk),
        .rst_n   (rst_n),
        .ptr_in  (rd_gray),
        .ptr_out (rd_gray_sync)
    );

    fifo_rd_ctrl i_rd_ctrl (
        .rd_clk       (rd_clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .wr_gray_sync (wr_gray_sync),
        .mem_rdata    (mem_rdata),
        .rd_addr      (rd_addr),
        .rd_gray      (rd_gray),
        .dout         (dout),
        .empty        (empty)
    );

endmodule : async_fifo_72

/* rtl/async_fifo_72/fifo_dp_ram.sv */
// Simple dual-port FIFO memory with clocked write and combinational read
`timescale 1ns/1ps

module fifo_dp_ram (
    input  logic                     wr_clk,    // Write domain clock
    input  logic                     wr_en,     // Write strobe from write controller
    input  fifo_cfg_pkg::fifo_addr_t wr_addr,   // Write slot
    input  fifo_data_pkg::fifo_word_t wr_data,  // Word to store
    input  fifo_cfg_pkg::fifo_addr_t rd_addr,   // Read slot from read controller
    output fifo_data_pkg::fifo_word_t rd_data   // Word at rd_addr
);

    import fifo_cfg_pkg::*;
    import fifo_data_pkg::*;

    // Storage array of fifo_depth words
    fifo_word_t mem [fifo_depth];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;    // One cycle write
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Asynchronous read
    // The read controller registers this into dout
    assign rd_data = mem[rd_addr];

endmodule : fifo_dp_ram

/* rtl/async_fifo_72/fifo_rd_ctrl.sv */
// Read-side reset synchronizer, read pointers, empty flag and FWFT output register
`timescale 1ns/1ps

module fifo_rd_ctrl (
    input  logic                      rd_clk,
    input  logic                      rst_n,         // Raw async reset
    input  logic                      rd_en,         // User read enable
    input  fifo_cfg_pkg::fifo_ptr_t   wr_gray_sync,  // Write pointer seen in read domain
    input  fifo_data_pkg::fifo_word_t mem_rdata,     // Combinational RAM data
    output fifo_cfg_pkg::fifo_addr_t  rd_addr,       // RAM read slot
    output fifo_cfg_pkg::fifo_ptr_t   rd_gray,       // Gray read pointer to write side
    output fifo_data_pkg::fifo_word_t dout,          // Oldest word while empty is low
    output logic                      empty
);

    import fifo_cfg_pkg::*;

    logic [1:0] rd_rst_sync;    // Reset release chain
    logic       rd_rst_n;       // Reset local to rd_clk
    fifo_ptr_t  rd_bin;         // Next RAM word to fetch
    fifo_ptr_t  rd_bin_gray;    // Fetch pointer in Gray form
    fifo_ptr_t  rd_pop;         // Words taken by the user
    fifo_ptr_t  rd_pop_next;
    logic       mem_avail;      // RAM holds words not yet fetched
    logic       rd_fire;        // Accepted read
    logic       load;           // Output register takes a new word

    //////////////////////////////
    // Reset synchronizer
    //////////////////////////////

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_rst_sync <= '0;
        end else begin
            rd_rst_sync <= {rd_rst_sync[0], 1'b1};   // Release after two rd_clk edges
        end
    end

    assign rd_rst_n = rd_rst_sync[1];

    //////////////////////////////
    // Fetch and pop control
    //////////////////////////////

    // Gray compare is exact since both sides use the same code
    assign rd_bin_gray = rd_bin ^ (rd_bin >> 1);
    assign mem_avail   = (rd_bin_gray != wr_gray_sync);

    assign rd_fire = rd_en & ~empty;                    // Reads while empty are ignored
    assign load    = (empty | rd_fire) & mem_avail;     // Refill an idle or drained register

    // The word held in dout still counts as stored
    // So the write side sees exactly 512 slots
    assign rd_pop_next = rd_pop + fifo_ptr_t'(rd_fire);

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin  <= '0;
            rd_pop  <= '0;
            rd_gray <= '0;
            empty   <= 1'b1;
        end else begin
            if (load) begin
                rd_bin <= rd_bin + 1'b1;    // Next word goes on the RAM address
            end
            rd_pop  <= rd_pop_next;
            rd_gray <= rd_pop_next ^ (rd_pop_next >> 1);
            if (load) begin
                empty <= 1'b0;              // Fresh word in dout
            end else if (rd_fire) begin
                empty <= 1'b1;              // Last word taken with nothing behind it
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Holds the oldest word while empty is low
    always_ff @(posedge rd_clk) begin
        if (load) begin
            dout <= mem_rdata;
        end
    end

    assign rd_addr = rd_bin[fifo_addr_w-1:0];

endmodule : fifo_rd_ctrl

/* rtl/async_fifo_72/fifo_wr_ctrl.sv */
// Write-side reset synchronizer, write pointers, memory write strobe and full flag
`timescale 1ns/1ps

module fifo_wr_ctrl (
    input  logic                     wr_clk,
    input  logic                     rst_n,          // Raw async reset
    input  logic                     wr_en,          // User write enable
    input  fifo_cfg_pkg::fifo_ptr_t  rd_gray_sync,   // Read pointer seen in write domain
    output logic                     mem_we,         // RAM write strobe
    output fifo_cfg_pkg::fifo_addr_t wr_addr,        // RAM write slot
    output fifo_cfg_pkg::fifo_ptr_t  wr_gray,        // Gray write pointer to read side
    output logic                     full
);

    import fifo_cfg_pkg::*;

    logic [1:0] wr_rst_sync;    // Reset release chain
    logic       wr_rst_n;       // Reset local to wr_clk
    fifo_ptr_t  wr_bin;         // Binary write pointer
    fifo_ptr_t  wr_bin_next;
    fifo_ptr_t  wr_gray_next;
    fifo_ptr_t  rd_gray_wrap;   // Read pointer one lap behind
    logic       wr_fire;        // Accepted write
    logic       full_next;

    //////////////////////////////
    // Reset synchronizer
    //////////////////////////////

    // Asserts at once and releases on the second wr_clk edge
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_rst_sync <= '0;
        end else begin
            wr_rst_sync <= {wr_rst_sync[0], 1'b1};
        end
    end

    assign wr_rst_n = wr_rst_sync[1];

    //////////////////////////////
    // Pointer and full flag
    //////////////////////////////

    assign wr_fire      = wr_en & ~full;                    // Writes while full are dropped
    assign wr_bin_next  = wr_bin + fifo_ptr_t'(wr_fire);
    assign wr_gray_next = wr_bin_next ^ (wr_bin_next >> 1);

    // Full when the writer is one whole lap ahead
    // In Gray code that flips the two top bits
    assign rd_gray_wrap = {~rd_gray_sync[fifo_ptr_w-1 -: 2], rd_gray_sync[fifo_ptr_w-3:0]};
    assign full_next    = (wr_gray_next == rd_gray_wrap);

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
            full    <= 1'b0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_gray_next;    // Registered so only one bit moves per edge
            full    <= full_next;       // Rises with the write that fills the last slot
        end
    end

    assign mem_we  = wr_fire;
    assign wr_addr = wr_bin[fifo_addr_w-1:0];   // Wrap bit dropped

endmodule : fifo_wr_ctrl

/* rtl/async_fifo_72/gray_ptr_sync.sv */
// Two-flop synchronizer for a Gray-coded FIFO pointer
`timescale 1ns/1ps

module gray_ptr_sync (
    input  logic                    clk,        // Destination domain clock
    input  logic                    rst_n,      // Async reset, active low
    input  fifo_cfg_pkg::fifo_ptr_t ptr_in,     // Gray pointer from source domain
    output fifo_cfg_pkg::fifo_ptr_t ptr_out     // Gray pointer in destination domain
);

    import fifo_cfg_pkg::*;

    // First stage may go metastable
    // Only one bit changes per step so the value is old or new
    fifo_ptr_t ptr_meta;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_meta <= '0;
            ptr_out  <= '0;
        end else begin
            ptr_meta <= ptr_in;     // Capture stage
            ptr_out  <= ptr_meta;   // Settled stage
        end
    end

endmodule : gray_ptr_sync
